/* core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and register file
`define LEN_WORD      32
`define LEN_REG_ADDR  5
`define NUM_REGS      32

// instruction fields
`define LEN_OPCODE    7
`define LEN_FUNC3     3
`define LEN_FUNC7     7

// alu_non_imm, alu_non_ext, fpu, mem, jump, branch, fbranch, subst, io
`define LEN_EXEC_TYPE 9

`endif

/* isa_pkg.sv */
`include "core_macros.svh"

package isa_pkg;

    // major opcodes handled by this slice
    typedef enum logic [`LEN_OPCODE-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // values follow funct3 of the branch encoding
    typedef enum logic [`LEN_FUNC3-1:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    // bit positions inside the exec type word, msb first
    typedef enum logic [3:0] {
        EXEC_IO          = 4'd0,
        EXEC_SUBST       = 4'd1,
        EXEC_FBRANCH     = 4'd2,
        EXEC_BRANCH      = 4'd3,
        EXEC_JUMP        = 4'd4,
        EXEC_MEM         = 4'd5,
        EXEC_FPU         = 4'd6,
        EXEC_ALU_NON_EXT = 4'd7,
        EXEC_ALU_NON_IMM = 4'd8
    } exec_bit_e;

    // decode issue condition
    typedef enum logic [1:0] {
        ISSUE_IDLE  = 2'd0,
        ISSUE_HOLD  = 2'd1,
        ISSUE_STALL = 2'd2
    } issue_state_e;

endpackage

/* reg_file.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`LEN_REG_ADDR-1:0] rs1_addr,
    input  logic [`LEN_REG_ADDR-1:0] rs2_addr,
    output logic [`LEN_WORD-1:0]     rs1_data,
    output logic [`LEN_WORD-1:0]     rs2_data,
    input  logic                     wb_en,
    input  logic [`LEN_REG_ADDR-1:0] wb_addr,
    input  logic [`LEN_WORD-1:0]     wb_data
);

    logic [`LEN_WORD-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* inst_decode.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module inst_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`LEN_WORD-1:0]      in_inst,
    input  logic [`LEN_WORD-1:0]      in_pc,
    output logic [`LEN_REG_ADDR-1:0]  rs1_addr,
    output logic [`LEN_REG_ADDR-1:0]  rs2_addr,
    input  logic [`LEN_WORD-1:0]      rs1_data,
    input  logic [`LEN_WORD-1:0]      rs2_data,
    input  logic                      wb_en,
    input  logic [`LEN_REG_ADDR-1:0]  wb_addr,
    output logic                      d_valid,
    input  logic                      d_ready,
    output logic [`LEN_EXEC_TYPE-1:0] d_exec_type,
    output isa_pkg::alu_op_e          d_alu_op,
    output isa_pkg::br_cond_e         d_br_cond,
    output logic [`LEN_REG_ADDR-1:0]  d_rd,
    output logic [`LEN_WORD-1:0]      d_a,
    output logic [`LEN_WORD-1:0]      d_b,
    output logic [`LEN_WORD-1:0]      d_imm,
    output logic [`LEN_WORD-1:0]      d_pc
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`LEN_OPCODE-1:0]    opcode;
    logic [`LEN_FUNC3-1:0]     funct3;
    logic [`LEN_FUNC7-1:0]     funct7;
    logic [`LEN_REG_ADDR-1:0]  rd;
    logic [`LEN_EXEC_TYPE-1:0] exec_type;
    logic [`LEN_WORD-1:0]      imm;
    alu_op_e                   alu_op;
    logic                      uses_rs1;
    logic                      uses_rs2;
    logic                      writes_rd;
    logic [`NUM_REGS-1:0]      pending;
    logic                      hazard;
    logic                      issue;
    issue_state_e              issue_state;

    assign opcode   = in_inst[6:0];
    assign rd       = in_inst[11:7];
    assign funct3   = in_inst[14:12];
    assign rs1_addr = in_inst[19:15];
    assign rs2_addr = in_inst[24:20];
    assign funct7   = in_inst[31:25];

    // classification and immediate select
    always_comb begin
        exec_type = '0;
        imm       = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin
                exec_type[EXEC_ALU_NON_IMM] = 1'b1;
                exec_type[EXEC_ALU_NON_EXT] = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                exec_type[EXEC_ALU_NON_EXT] = 1'b1;
                imm       = {{20{in_inst[31]}}, in_inst[31:20]};
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_LUI: begin
                exec_type[EXEC_SUBST] = 1'b1;
                imm       = {in_inst[31:12], 12'b0};
                writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                exec_type[EXEC_BRANCH] = 1'b1;
                imm = {{19{in_inst[31]}}, in_inst[31], in_inst[7],
                       in_inst[30:25], in_inst[11:8], 1'b0};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPC_JAL: begin
                exec_type[EXEC_JUMP] = 1'b1;
                imm = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12],
                       in_inst[20], in_inst[30:21], 1'b0};
                writes_rd = 1'b1;
            end
            OPC_JALR: begin
                exec_type[EXEC_JUMP] = 1'b1;
                imm       = {{20{in_inst[31]}}, in_inst[31:20]};
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            // anything else retires as a no-op
            default: ;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    // operands pending, or rd still owed by an older write
    assign hazard = (uses_rs1 && rs1_addr != '0 && pending[rs1_addr])
                 || (uses_rs2 && rs2_addr != '0 && pending[rs2_addr])
                 || (writes_rd && rd != '0 && pending[rd]);

    always_comb begin
        if (in_valid && hazard) begin
            issue_state = ISSUE_STALL;
        end else if (d_valid && !d_ready) begin
            issue_state = ISSUE_HOLD;
        end else begin
            issue_state = ISSUE_IDLE;
        end
    end

    assign in_ready = (issue_state == ISSUE_IDLE);
    assign issue    = in_valid && in_ready;

    // clear first so a same-cycle set wins
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (wb_en) begin
                pending[wb_addr] <= 1'b0;
            end
            if (issue && writes_rd && rd != '0) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    // register empties during a stall once execute takes its content
    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else if (!d_valid || d_ready) begin
            d_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            d_exec_type <= exec_type;
            d_alu_op    <= alu_op;
            d_br_cond   <= br_cond_e'(funct3);
            d_rd        <= rd;
            // jal takes its base from pc
            d_a         <= (opcode == OPC_JAL) ? in_pc : rs1_data;
            d_b         <= rs2_data;
            d_imm       <= imm;
            d_pc        <= in_pc;
        end
    end

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      d_valid,
    output logic                      d_ready,
    input  logic [`LEN_EXEC_TYPE-1:0] d_exec_type,
    input  isa_pkg::alu_op_e          d_alu_op,
    input  isa_pkg::br_cond_e         d_br_cond,
    input  logic [`LEN_REG_ADDR-1:0]  d_rd,
    input  logic [`LEN_WORD-1:0]      d_a,
    input  logic [`LEN_WORD-1:0]      d_b,
    input  logic [`LEN_WORD-1:0]      d_imm,
    input  logic [`LEN_WORD-1:0]      d_pc,
    output logic                      e_valid,
    input  logic                      e_ready,
    output logic [`LEN_REG_ADDR-1:0]  e_rd,
    output logic                      e_we,
    output logic [`LEN_WORD-1:0]      e_data,
    output logic                      e_redirect,
    output logic [`LEN_WORD-1:0]      e_target,
    output logic [`LEN_WORD-1:0]      e_pc
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                 alu_std;
    logic                 alu_imm;
    logic                 taken;
    logic [`LEN_WORD-1:0] jump_sum;
    logic [`LEN_WORD-1:0] res;
    logic                 we;
    logic                 redirect;
    logic [`LEN_WORD-1:0] target;

    function automatic logic [`LEN_WORD-1:0] alu(input alu_op_e op,
                                                 input logic [`LEN_WORD-1:0] a,
                                                 input logic [`LEN_WORD-1:0] b);
        logic [4:0] shamt;
        shamt = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << shamt;
            ALU_SLT:  return {{(`LEN_WORD-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: return {{(`LEN_WORD-1){1'b0}}, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> shamt;
            ALU_SRA:  return $signed(a) >>> shamt;
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    assign alu_std = d_exec_type[EXEC_ALU_NON_EXT] & d_exec_type[EXEC_ALU_NON_IMM];
    assign alu_imm = d_exec_type[EXEC_ALU_NON_EXT] & ~d_exec_type[EXEC_ALU_NON_IMM];

    always_comb begin
        case (d_br_cond)
            BR_EQ:   taken = (d_a == d_b);
            BR_NE:   taken = (d_a != d_b);
            BR_LT:   taken = ($signed(d_a) < $signed(d_b));
            BR_GE:   taken = ($signed(d_a) >= $signed(d_b));
            BR_LTU:  taken = (d_a < d_b);
            BR_GEU:  taken = (d_a >= d_b);
            default: taken = 1'b0;
        endcase
    end

    // d_a holds pc for jal, rs1 for jalr
    assign jump_sum = d_a + d_imm;

    always_comb begin
        res      = '0;
        we       = 1'b0;
        redirect = 1'b0;
        target   = '0;
        if (alu_std) begin
            res = alu(d_alu_op, d_a, d_b);
            we  = 1'b1;
        end else if (alu_imm) begin
            res = alu(d_alu_op, d_a, d_imm);
            we  = 1'b1;
        end else if (d_exec_type[EXEC_SUBST]) begin
            res = d_imm;
            we  = 1'b1;
        end else if (d_exec_type[EXEC_JUMP]) begin
            res      = d_pc + 32'd4;
            we       = 1'b1;
            redirect = 1'b1;
            target   = {jump_sum[`LEN_WORD-1:1], 1'b0};
        end else if (d_exec_type[EXEC_BRANCH]) begin
            redirect = taken;
            target   = taken ? d_pc + d_imm : '0;
        end
    end

    assign d_ready = !e_valid || e_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid <= 1'b0;
        end else if (d_ready) begin
            e_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid && d_ready) begin
            e_rd       <= d_rd;
            e_we       <= we;
            e_data     <= res;
            e_redirect <= redirect;
            e_target   <= target;
            e_pc       <= d_pc;
        end
    end

endmodule

/* result_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module result_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     e_valid,
    output logic                     e_ready,
    input  logic [`LEN_REG_ADDR-1:0] e_rd,
    input  logic                     e_we,
    input  logic [`LEN_WORD-1:0]     e_data,
    input  logic                     e_redirect,
    input  logic [`LEN_WORD-1:0]     e_target,
    input  logic [`LEN_WORD-1:0]     e_pc,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`LEN_WORD-1:0]     out_pc,
    output logic [`LEN_REG_ADDR-1:0] out_rd,
    output logic                     out_we,
    output logic [`LEN_WORD-1:0]     out_data,
    output logic                     out_redirect,
    output logic [`LEN_WORD-1:0]     out_target,
    output logic                     wb_en,
    output logic [`LEN_REG_ADDR-1:0] wb_addr,
    output logic [`LEN_WORD-1:0]     wb_data
);

    assign e_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (e_ready) begin
            out_valid <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (e_valid && e_ready) begin
            out_pc       <= e_pc;
            out_rd       <= e_rd;
            // no write for x0
            out_we       <= e_we && (e_rd != '0);
            out_data     <= e_data;
            out_redirect <= e_redirect;
            out_target   <= e_target;
        end
    end

    // write-back commits with the retiring transfer
    assign wb_en   = out_valid && out_ready && out_we;
    assign wb_addr = out_rd;
    assign wb_data = out_data;

endmodule

/* exec_top.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`LEN_WORD-1:0]     in_inst,
    input  logic [`LEN_WORD-1:0]     in_pc,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`LEN_WORD-1:0]     out_pc,
    output logic [`LEN_REG_ADDR-1:0] out_rd,
    output logic                     out_we,
    output logic [`LEN_WORD-1:0]     out_data,
    output logic                     out_redirect,
    output logic [`LEN_WORD-1:0]     out_target
);
    import isa_pkg::*;

    // register file ports
    logic [`LEN_REG_ADDR-1:0]  rs1_addr;
    logic [`LEN_REG_ADDR-1:0]  rs2_addr;
    logic [`LEN_WORD-1:0]      rs1_data;
    logic [`LEN_WORD-1:0]      rs2_data;
    logic                      wb_en;
    logic [`LEN_REG_ADDR-1:0]  wb_addr;
    logic [`LEN_WORD-1:0]      wb_data;

    // decode to execute
    logic                      d_valid;
    logic                      d_ready;
    logic [`LEN_EXEC_TYPE-1:0] d_exec_type;
    alu_op_e                   d_alu_op;
    br_cond_e                  d_br_cond;
    logic [`LEN_REG_ADDR-1:0]  d_rd;
    logic [`LEN_WORD-1:0]      d_a;
    logic [`LEN_WORD-1:0]      d_b;
    logic [`LEN_WORD-1:0]      d_imm;
    logic [`LEN_WORD-1:0]      d_pc;

    // execute to result
    logic                      e_valid;
    logic                      e_ready;
    logic [`LEN_REG_ADDR-1:0]  e_rd;
    logic                      e_we;
    logic [`LEN_WORD-1:0]      e_data;
    logic                      e_redirect;
    logic [`LEN_WORD-1:0]      e_target;
    logic [`LEN_WORD-1:0]      e_pc;

    inst_decode u_inst_decode (.*);

    reg_file u_reg_file (.*);

    exec_unit u_exec_unit (.*);

    result_stage u_result_stage (.*);

endmodule

/* exec_top_properties.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_top_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [`LEN_WORD-1:0]     out_pc,
    input logic [`LEN_REG_ADDR-1:0] out_rd,
    input logic                     out_we,
    input logic [`LEN_WORD-1:0]     out_data,
    input logic                     out_redirect,
    input logic [`LEN_WORD-1:0]     out_target,
    input logic                     wb_en
);

    int fail_count = 0;

    // nothing moves while reset is applied
    reset_no_output: assert property (@(posedge clk) reset |=> !out_valid && !wb_en)
        else begin
            $error("output valid or register write right after a reset cycle");
            fail_count++;
        end

    reset_no_write: assert property (@(posedge clk) reset |-> !wb_en)
        else begin
            $error("register write during reset");
            fail_count++;
        end

    // stalled output keeps its content
    output_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_rd)
            && $stable(out_we) && $stable(out_data) && $stable(out_redirect)
            && $stable(out_target))
        else begin
            $error("output changed or dropped while out_ready was low");
            fail_count++;
        end

endmodule

bind exec_top exec_top_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_pc       (out_pc),
    .out_rd       (out_rd),
    .out_we       (out_we),
    .out_data     (out_data),
    .out_redirect (out_redirect),
    .out_target   (out_target),
    .wb_en        (wb_en)
);

/* tb_exec_top.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_exec_top;
    import isa_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_RESET    = 4;
    localparam int N_ARITH    = 48;
    localparam int N_DEP      = 24;
    localparam int N_CTRL     = 28;
    localparam int N_BP       = 40;
    localparam int N_ILLEGAL  = 8;
    localparam int N_TOTAL    = N_RESET + N_ARITH + N_DEP + N_CTRL + N_BP + N_ILLEGAL;
    localparam int LIMIT      = 40 * N_TOTAL + 200;

    typedef struct packed {
        logic [`LEN_WORD-1:0]     pc;
        logic [`LEN_REG_ADDR-1:0] rd;
        logic                     we;
        logic [`LEN_WORD-1:0]     data;
        logic                     redirect;
        logic [`LEN_WORD-1:0]     target;
    } result_t;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    logic [`LEN_WORD-1:0]     in_inst;
    logic [`LEN_WORD-1:0]     in_pc;
    logic                     out_valid;
    logic                     out_ready;
    logic [`LEN_WORD-1:0]     out_pc;
    logic [`LEN_REG_ADDR-1:0] out_rd;
    logic                     out_we;
    logic [`LEN_WORD-1:0]     out_data;
    logic                     out_redirect;
    logic [`LEN_WORD-1:0]     out_target;

    // reference model state
    logic [`LEN_WORD-1:0] ref_regs [`NUM_REGS];
    result_t              expected [$];
    result_t              head;
    logic [`LEN_WORD-1:0] pc_next;
    logic                 bp_on;
    int                   errors;
    int                   issued;
    int                   retired;
    int                   tests;
    int                   issued_mark;
    int                   error_mark;
    int                   total;
    logic [11:0]          lhs [3] = '{12'd5, 12'hffd, 12'd7};
    logic [11:0]          rhs [3] = '{12'd5, 12'd7, 12'hffd};
    logic [2:0]           conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [4:0]           prev;
    logic [4:0]           next;

    exec_top u_exec_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // random stalls on the output side
    always @(negedge clk) begin
        if (bp_on) begin
            out_ready = (($urandom % 100) >= 45);
        end else begin
            out_ready = 1'b1;
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic with_lui);
        logic [2:0]  f3;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [1:0]  pick;
        f3   = 3'($urandom);
        rs2  = 5'($urandom);
        imm  = 12'($urandom);
        pick = 2'($urandom);
        if (with_lui && pick == 2'd0) begin
            return enc_u(20'($urandom), rd);
        end
        if (pick == 2'd1) begin
            // only add and the right shift have a second form
            if ((f3 == 3'd0 || f3 == 3'd5) && 1'($urandom)) begin
                return enc_r(7'h20, rs2, rs1, f3, rd);
            end
            return enc_r(7'h00, rs2, rs1, f3, rd);
        end
        if (f3 == 3'd1) begin
            imm = {7'h00, imm[4:0]};
        end else if (f3 == 3'd5) begin
            imm = {imm[10] ? 7'h20 : 7'h00, imm[4:0]};
        end
        return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0: alu_ref = alt ? x - y : x + y;
            3'd1: alu_ref = x << y[4:0];
            3'd2: alu_ref = {31'd0, $signed(x) < $signed(y)};
            3'd3: alu_ref = {31'd0, x < y};
            3'd4: alu_ref = x ^ y;
            3'd5: begin
                if (alt) begin
                    alu_ref = $signed(x) >>> y[4:0];
                end else begin
                    alu_ref = x >> y[4:0];
                end
            end
            3'd6: alu_ref = x | y;
            default: alu_ref = x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                          input logic [31:0] y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return $signed(x) < $signed(y);
            3'd5: return $signed(x) >= $signed(y);
            3'd6: return x < y;
            3'd7: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int error_total();
        return errors + u_exec_top.u_props.fail_count;
    endfunction

    // executes one instruction in program order and queues its result
    task automatic run_model(input logic [31:0] inst, input logic [31:0] pc);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        result_t     r;
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = ref_regs[inst[19:15]];
        b     = ref_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        r = '0;
        r.pc = pc;
        r.rd = rd;
        case (inst[6:0])
            OPC_OP: begin
                r.we   = 1'b1;
                r.data = alu_ref(f3, inst[30], a, b);
            end
            OPC_OP_IMM: begin
                r.we   = 1'b1;
                r.data = alu_ref(f3, f3 == 3'd5 && inst[30], a, imm_i);
            end
            OPC_LUI: begin
                r.we   = 1'b1;
                r.data = {inst[31:12], 12'd0};
            end
            OPC_BRANCH: begin
                r.redirect = branch_taken(f3, a, b);
                r.target   = pc + imm_b;
            end
            OPC_JAL, OPC_JALR: begin
                r.we       = 1'b1;
                r.data     = pc + 32'd4;
                r.redirect = 1'b1;
                r.target   = (inst[6:0] == OPC_JAL) ? pc + imm_j : a + imm_i;
                r.target   = r.target & ~32'd1;
            end
            default: ;
        endcase
        r.we = r.we && rd != 5'd0;
        if (r.we) begin
            ref_regs[rd] = r.data;
        end
        expected.push_back(r);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input logic [31:0] inst);
        logic accepted;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_inst  = inst;
        in_pc    = pc_next;
        while (!accepted) begin
            #1;
            accepted = in_ready;
            if (accepted) begin
                run_model(inst, pc_next);
            end
            @(negedge clk);
        end
        pc_next = pc_next + 32'd4;
        issued++;
    endtask

    task automatic test_done(input string name);
        int now_errors;
        in_valid = 1'b0;
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        now_errors = error_total();
        tests++;
        $display("test %0d %s: %0d instructions, %0d errors", tests, name,
                 issued - issued_mark, now_errors - error_mark);
        issued_mark = issued;
        error_mark  = now_errors;
    endtask

    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            retired++;
            if (expected.size() == 0) begin
                $display("unexpected output transfer at %0t for pc %h", $time, out_pc);
                errors++;
            end else begin
                head = expected.pop_front();
                assert (out_pc == head.pc && out_rd == head.rd && out_we == head.we
                        && (!head.we || out_data == head.data)
                        && out_redirect == head.redirect
                        && (!head.redirect || out_target == head.target))
                else begin
                    $display("[FAIL] %0t: pc %h got rd %0d we %b data %h redir %b tgt %h",
                             $time, out_pc, out_rd, out_we, out_data, out_redirect,
                             out_target);
                    $display("[FAIL] %0t: pc %h want rd %0d we %b data %h redir %b tgt %h",
                             $time, head.pc, head.rd, head.we, head.data, head.redirect,
                             head.target);
                    errors++;
                end
            end
        end
    end

    // watchdog sized from the instruction count
    initial begin
        #(CLK_PERIOD * LIMIT);
        $display("timeout: results still missing after %0d cycles", LIMIT);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'hd3df_506b));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_inst   = '0;
        in_pc     = '0;
        out_ready = 1'b1;
        bp_on     = 1'b0;
        pc_next   = 32'h0000_1000;
        errors    = 0;
        issued    = 0;
        retired   = 0;
        tests     = 0;
        issued_mark = 0;
        error_mark  = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // everything reads zero straight after reset
        for (int i = 0; i < N_RESET; i++) begin
            send(enc_r(7'h00, 5'($urandom), 5'($urandom), 3'($urandom), 5'($urandom)));
        end
        test_done("reset");

        for (int i = 0; i < N_ARITH; i++) begin
            send(random_alu((i % 8 == 0) ? 5'd0 : 5'($urandom), 5'($urandom), 1'b1));
        end
        test_done("arithmetic");

        prev = 5'd1 + 5'($urandom % 31);
        for (int i = 0; i < N_DEP; i++) begin
            next = 5'd1 + 5'($urandom % 31);
            send(random_alu(next, prev, 1'b0));
            prev = next;
        end
        test_done("dependencies");

        // x1 and x2 get equal, smaller and larger pairs, signed and unsigned
        for (int p = 0; p < 3; p++) begin
            send(enc_i(lhs[p], 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
            send(enc_i(rhs[p], 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
            for (int c = 0; c < 6; c++) begin
                send(enc_b({12'($urandom), 1'b0}, 5'd2, 5'd1, conds[c]));
            end
        end
        send(enc_j({20'($urandom), 1'b0}, 5'($urandom)));
        send(enc_j({20'($urandom), 1'b0}, 5'd0));
        send(enc_i(12'($urandom), 5'd1, 3'd0, 5'($urandom), OPC_JALR));
        send(enc_i(12'($urandom) | 12'd1, 5'd1, 3'd0, 5'd3, OPC_JALR));
        test_done("control flow");

        bp_on = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            send(random_alu(5'($urandom), 5'($urandom), 1'b1));
        end
        test_done("back-pressure");
        bp_on = 1'b0;

        // a load and a store, then normal work
        send(enc_i(12'($urandom), 5'($urandom), 3'd2, 5'd1 + 5'($urandom % 31), 7'b0000011));
        send({25'($urandom), 7'b0100011});
        for (int i = 0; i < N_ILLEGAL - 2; i++) begin
            send(random_alu(5'($urandom), 5'($urandom), 1'b1));
        end
        test_done("unsupported");

        repeat (20) @(negedge clk);
        if (retired != issued) begin
            $display("lost or duplicated instructions: %0d issued, %0d retired",
                     issued, retired);
            errors++;
        end
        total = error_total();
        $display("summary: %0d tests, %0d issued, %0d retired, %0d errors",
                 tests, issued, retired, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
inst_decode.sv
exec_unit.sv
result_stage.sv
exec_top.sv
exec_top_properties.sv
tb_exec_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec_top testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_exec_top \
    -f files.f \
    --Mdir obj_dir \
    -o tb_exec_top

status=0
./obj_dir/tb_exec_top +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
